/* aes_out_stream.f */
src/aes_out_pkg.sv
src/block_fifo.sv
src/axis_block_master.sv
src/aes_out_stream.sv
dv/aes_out_stream_asserts.sv
dv/tb_aes_out_stream.sv

/* dv/aes_out_stream_asserts.sv */
// Stream and credit protocol assertions, bound onto the aes_out_stream top level.
`default_nettype none

module aes_out_stream_asserts (
	input wire                         m00_axis_aclk,
	input wire                         rst_n,
	input wire aes_out_pkg::blk_in_t   blk_in,
	input wire                         processing_done,
	input wire                         m00_axis_tready,
	input wire                         credit_return,
	input wire aes_out_pkg::axis_out_t m_axis,
	input wire                         stream_done
);

	import aes_out_pkg::*;

	int unsigned           wr_cnt;	// blocks written so far.
	int unsigned           ret_cnt;	// credits handed back so far.
	logic [WORD_IDX_W-1:0] beat_idx;	// position of the next word in its block.
	logic                  tlast_seen;
	logic                  beat;

	assign beat = m_axis.tvalid && m00_axis_tready;

	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_cnt     <= 32'd0;
			ret_cnt    <= 32'd0;
			beat_idx   <= '0;
			tlast_seen <= 1'b0;
		end else begin
			if (blk_in.valid) begin
				wr_cnt <= wr_cnt + 32'd1;
			end
			if (credit_return) begin
				ret_cnt <= ret_cnt + 32'd1;
			end
			if (beat) begin
				beat_idx <= beat_idx + 1'b1;	// wraps every block.
				if (m_axis.tlast) begin
					tlast_seen <= 1'b1;
				end
			end
		end
	end

	// quiet outputs while in reset and right after it
	a_reset_quiet: assert property (@(posedge m00_axis_aclk)
		!rst_n |-> !m_axis.tvalid && !credit_return && !stream_done)
		else $error("stream or credit output active during reset");

	a_reset_exit: assert property (@(posedge m00_axis_aclk)
		$rose(rst_n) |=> !m_axis.tvalid && !credit_return && !stream_done)
		else $error("stream or credit output active on first cycle after reset");

	// stalled word stays on the bus unchanged
	a_hold: assert property (@(posedge m00_axis_aclk) disable iff (!rst_n)
		m_axis.tvalid && !m00_axis_tready |=>
			m_axis.tvalid && $stable(m_axis.tdata) && $stable(m_axis.tlast))
		else $error("stream word changed while stalled");

	a_credit: assert property (@(posedge m00_axis_aclk) disable iff (!rst_n)
		credit_return |-> ret_cnt < wr_cnt)
		else $error("more credits returned than blocks written");

	a_tlast: assert property (@(posedge m00_axis_aclk) disable iff (!rst_n)
		m_axis.tvalid && m_axis.tlast |->
			processing_done && !tlast_seen &&
			beat_idx == WORD_IDX_W'(WORDS_PER_BLOCK - 1))
		else $error("tlast outside the last word of the final block");

	a_done_set: assert property (@(posedge m00_axis_aclk) disable iff (!rst_n)
		beat && m_axis.tlast |=> stream_done)
		else $error("stream_done missing after the final word");

	a_done_early: assert property (@(posedge m00_axis_aclk) disable iff (!rst_n)
		!tlast_seen |-> !stream_done)
		else $error("stream_done raised before the final word");

endmodule : aes_out_stream_asserts

bind aes_out_stream aes_out_stream_asserts u_asserts (
	.m00_axis_aclk   (m00_axis_aclk),
	.rst_n           (rst_n),
	.blk_in          (blk_in),
	.processing_done (processing_done),
	.m00_axis_tready (m00_axis_tready),
	.credit_return   (credit_return),
	.m_axis          (m_axis),
	.stream_done     (stream_done)
);

`default_nettype wire

/* dv/tb_aes_out_stream.sv */
// Testbench for aes_out_stream with credit-limited block writes, a word scoreboard and a watchdog.
`default_nettype none

module tb_aes_out_stream;

	import aes_out_pkg::*;

	localparam int NUM_BLOCKS      = 40;
	localparam int TOTAL_WORDS     = NUM_BLOCKS * WORDS_PER_BLOCK;
	localparam int RESET_CYCLES    = 8;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 8 + 400;

	logic      m00_axis_aclk;
	logic      rst_n;
	blk_in_t   blk_in;
	logic      processing_done;
	logic      m00_axis_tready;
	logic      credit_return;
	axis_out_t m_axis;
	logic      stream_done;

	logic [WORD_W-1:0] exp_q[$];	// expected words in stream order.
	logic [31:0]       rng_state = 32'd79;
	int                wr_count  = 0;	// blocks driven so far.
	int                ret_count = 0;	// credit_return pulses seen.
	int                rcvd      = 0;	// words accepted by the sink.
	int                tlast_count = 0;

	aes_out_stream DUT (
		.m00_axis_aclk   (m00_axis_aclk),
		.rst_n           (rst_n),
		.blk_in          (blk_in),
		.processing_done (processing_done),
		.m00_axis_tready (m00_axis_tready),
		.credit_return   (credit_return),
		.m_axis          (m_axis),
		.stream_done     (stream_done)
	);

	initial begin
		m00_axis_aclk = 1'b0;
		forever #20 m00_axis_aclk = ~m00_axis_aclk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;	// LCG step.
		return rng_state;
	endfunction

	function automatic bit value_ok(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s = 0x%0h, expected 0x%0h", name, got, exp);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic halt_failed();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic fail_because(input string why);
		$display("ERROR: %s", why);
		halt_failed();
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (!value_ok(name, got, exp)) begin
			halt_failed();
		end
	endtask

	// new random block, queued as words with the most significant word first
	task automatic drive_block();
		aes_block_t blk;
		for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
			blk[i*WORD_W +: WORD_W] = next_rand();
		end
		for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
			exp_q.push_back(blk[(WORDS_PER_BLOCK - 1 - k)*WORD_W +: WORD_W]);
		end
		blk_in.data  = blk;
		blk_in.valid = 1'b1;
		wr_count++;
	endtask

	// sink side, sampled mid-cycle where outputs are settled
	always @(negedge m00_axis_aclk) begin : monitor
		logic [WORD_W-1:0] exp_word;
		bit                exp_last;
		if (rst_n) begin
			if (credit_return) begin
				ret_count++;
			end
			if (stream_done && tlast_count == 0) begin
				fail_because("stream_done is high before the final word transferred");
			end
			if (m_axis.tvalid && m00_axis_tready) begin
				if (exp_q.size() == 0) begin
					fail_because("a word was transferred with no block outstanding");
				end else begin
					exp_word = exp_q.pop_front();
					exp_last = (rcvd == TOTAL_WORDS - 1);	// only the 160th word.
					check_value("m_axis.tdata", 128'(m_axis.tdata), 128'(exp_word));
					check_value("m_axis.tlast", 128'(m_axis.tlast), 128'(exp_last));
					if (m_axis.tlast) begin
						tlast_count++;
					end
					rcvd++;
				end
			end
		end
	end

	initial begin : stimulus
		logic [31:0] r;
		int          credits;
		int          stall_left;
		bit          ok;
		rst_n           = 1'b0;
		blk_in          = '0;
		processing_done = 1'b0;
		m00_axis_tready = 1'b0;
		stall_left      = 40;	// opening stall fills the FIFO.
		repeat (RESET_CYCLES) @(posedge m00_axis_aclk);
		#1;
		rst_n = 1'b1;

		while (rcvd < TOTAL_WORDS) begin
			@(posedge m00_axis_aclk);
			#1;
			// sink, with long stalls now and then.
			if (stall_left > 0) begin
				m00_axis_tready = 1'b0;
				stall_left--;
			end else begin
				r = next_rand();
				if (r[10:5] == 6'd0) begin
					stall_left      = 40 + int'(r[3:0]);
					m00_axis_tready = 1'b0;
				end else begin
					m00_axis_tready = (r[1:0] != 2'b00);
				end
			end
			// producer, one block per credit.
			blk_in.valid = 1'b0;
			if (wr_count < NUM_BLOCKS) begin
				r       = next_rand();
				credits = FIFO_DEPTH - wr_count + ret_count;
				if (credits > 0 && r[1:0] != 2'b00) begin
					drive_block();
				end
			end else begin
				processing_done = 1'b1;	// level, stays up to the end.
			end
		end

		repeat (2) @(negedge m00_axis_aclk);
		ok = 1'b1;
		if (!value_ok("stream_done", 128'(stream_done), 128'(1))) begin
			ok = 1'b0;
		end else if (!value_ok("credit returns", 128'(ret_count), 128'(NUM_BLOCKS))) begin
			ok = 1'b0;
		end else if (!value_ok("tlast count", 128'(tlast_count), 128'(1))) begin
			ok = 1'b0;
		end else if (!value_ok("words left in scoreboard", 128'(exp_q.size()), 128'(0))) begin
			ok = 1'b0;
		end
		if (ok) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			halt_failed();
		end
	end

	initial begin : watchdog
		repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge m00_axis_aclk);
		fail_because("watchdog expired before all stream words were received");
	end

endmodule : tb_aes_out_stream

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_aes_out_stream \
	--Mdir obj_dir -o sim_aes_out_stream \
	-f aes_out_stream.f

./obj_dir/sim_aes_out_stream 2>&1 | tee sim.log

if grep -qxF '*** TEST PASSED ***' sim.log; then
	echo "simulation passed, see sim.log"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* src/aes_out_pkg.sv */
// Sizes and bus structs for the AES output stream, imported by every module of the design.
`default_nettype none

package aes_out_pkg;

	// block and stream geometry
	localparam int BLOCK_W         = 128;	// one AES cipher block.
	localparam int WORD_W          = 32;	// one stream word.
	localparam int WORDS_PER_BLOCK = BLOCK_W / WORD_W;
	localparam int WORD_IDX_W      = 2;	// enough for WORDS_PER_BLOCK.

	// block FIFO
	localparam int FIFO_DEPTH = 16;	// also the producer's starting credits.
	localparam int FIFO_AW    = 4;

	typedef logic [BLOCK_W-1:0] aes_block_t;

	// block write from the producer side
	typedef struct packed {
		logic       valid;	// one block per cycle, needs a credit.
		aes_block_t data;
	} blk_in_t;

	// master outputs of the stream, tstrb is implied all ones
	typedef struct packed {
		logic              tvalid;
		logic [WORD_W-1:0] tdata;
		logic              tlast;
	} axis_out_t;

endpackage : aes_out_pkg

`default_nettype wire

/* src/aes_out_stream.sv */
// Top level of the AES output side, which takes producer blocks and drives the stream sink.
`default_nettype none

module aes_out_stream (
	input  wire                         m00_axis_aclk,
	input  wire                         rst_n,
	input  wire aes_out_pkg::blk_in_t   blk_in,
	input  wire                         processing_done,
	input  wire                         m00_axis_tready,
	output logic                        credit_return,
	output aes_out_pkg::axis_out_t      m_axis,
	output logic                        stream_done
);

	import aes_out_pkg::*;

	aes_block_t rd_data;	// block at the FIFO read port.
	logic       fifo_empty;
	logic       fifo_pop;

	// block storage and credit return.
	block_fifo u_block_fifo (
		.m00_axis_aclk (m00_axis_aclk),
		.rst_n         (rst_n),
		.blk_in        (blk_in),
		.fifo_pop      (fifo_pop),
		.rd_data       (rd_data),
		.fifo_empty    (fifo_empty),
		.credit_return (credit_return)
	);

	// block to word serializer.
	axis_block_master u_axis_block_master (
		.m00_axis_aclk   (m00_axis_aclk),
		.rst_n           (rst_n),
		.fifo_empty      (fifo_empty),
		.rd_data         (rd_data),
		.processing_done (processing_done),
		.m00_axis_tready (m00_axis_tready),
		.fifo_pop        (fifo_pop),
		.m_axis          (m_axis),
		.stream_done     (stream_done)
	);

endmodule : aes_out_stream

`default_nettype wire

/* src/axis_block_master.sv */
// AXI4-Stream master FSM that pops one block from the FIFO and sends it as four words.
`default_nettype none

module axis_block_master (
	input  wire                           m00_axis_aclk,
	input  wire                           rst_n,
	input  wire                           fifo_empty,
	input  wire aes_out_pkg::aes_block_t  rd_data,
	input  wire                           processing_done,
	input  wire                           m00_axis_tready,
	output logic                          fifo_pop,
	output aes_out_pkg::axis_out_t        m_axis,
	output logic                          stream_done
);

	import aes_out_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,	// waiting for a block in the FIFO.
		ST_LOAD,	// pop strobe out, read data not yet there.
		ST_XFER		// words of the block on the bus.
	} state_t;

	state_t                state;
	logic [WORD_IDX_W-1:0] word_idx;	// word on the bus, 0 is sent first.
	logic [WORD_IDX_W-1:0] word_sel;	// same word counted from the lsb.
	logic                  last_word;
	logic                  final_blk;
	logic                  beat;	// a word moves this cycle.

	assign last_word = (word_idx == WORD_IDX_W'(WORDS_PER_BLOCK - 1));
	assign word_sel  = WORD_IDX_W'(WORDS_PER_BLOCK - 1) - word_idx;

	// nothing more will arrive once the core is done and the FIFO is drained
	assign final_blk = processing_done && fifo_empty;

	// Stream outputs decode from state and word index only, so they stay
	// steady under back-pressure while rd_data holds the current block.
	always_comb begin
		m_axis.tvalid = (state == ST_XFER);
		m_axis.tdata  = rd_data[word_sel*WORD_W +: WORD_W];	// msw first.
		m_axis.tlast  = (state == ST_XFER) && last_word && final_blk;
	end

	assign beat = m_axis.tvalid && m00_axis_tready;

	// block sequencing.
	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			word_idx <= '0;
			fifo_pop <= 1'b0;
		end else begin
			fifo_pop <= 1'b0;	// single-cycle strobe.

			case (state)
				ST_IDLE: begin
					word_idx <= '0;
					if (!fifo_empty) begin
						fifo_pop <= 1'b1;
						state    <= ST_LOAD;
					end
				end

				ST_LOAD: begin
					state <= ST_XFER;	// FIFO pops and loads rd_data here.
				end

				ST_XFER: begin
					if (beat) begin
						word_idx <= word_idx + 1'b1;	// wraps to 0 after the last word.
						if (last_word) begin
							state <= ST_IDLE;
						end
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// sticky done, cleared when the core drops processing_done.
	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			stream_done <= 1'b0;
		end else if (!processing_done) begin
			stream_done <= 1'b0;
		end else if (beat && m_axis.tlast) begin
			stream_done <= 1'b1;	// final word accepted by the sink.
		end
	end

endmodule : axis_block_master

`default_nettype wire

/* src/block_fifo.sv */
// Circular block FIFO between the AES core and the stream master, returning a credit per pop.
`default_nettype none

module block_fifo (
	input  wire                          m00_axis_aclk,
	input  wire                          rst_n,
	input  wire aes_out_pkg::blk_in_t    blk_in,
	input  wire                          fifo_pop,
	output aes_out_pkg::aes_block_t      rd_data,
	output logic                         fifo_empty,
	output logic                         credit_return
);

	import aes_out_pkg::*;

	aes_block_t           mem [FIFO_DEPTH];	// block storage.
	logic [FIFO_AW-1:0]   wr_ptr;
	logic [FIFO_AW-1:0]   rd_ptr;
	logic [FIFO_AW:0]     count;	// occupancy, 0 to FIFO_DEPTH.
	logic                 fifo_full;
	logic                 do_push;
	logic                 do_pop;

	// status flags come straight from the occupancy count
	assign fifo_empty = (count == '0);
	assign fifo_full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

	// the producer only writes with a credit, so a full FIFO is never written
	assign do_push = blk_in.valid && !fifo_full;
	assign do_pop  = fifo_pop && !fifo_empty;

	// storage write port.
	always_ff @(posedge m00_axis_aclk) begin
		if (do_push) begin
			mem[wr_ptr] <= blk_in.data;
		end
	end

	// registered read port, block RAM style.
	always_ff @(posedge m00_axis_aclk) begin
		if (do_pop) begin
			rd_data <= mem[rd_ptr];	// holds until the next pop.
		end
	end

	// pointers wrap naturally at FIFO_DEPTH.
	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// occupancy count.
	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;	// idle, or push and pop together.
				end
			endcase
		end
	end

	// one credit back for every freed entry, the cycle after the pop.
	always_ff @(posedge m00_axis_aclk or negedge rst_n) begin
		if (!rst_n) begin
			credit_return <= 1'b0;
		end else begin
			credit_return <= do_pop;
		end
	end

endmodule : block_fifo

`default_nettype wire
